// File: cpu_defs.svh
//==========================================================================
// widths and reset vector of the MIPS32 subset pipeline
// the values are fixed by the instruction set and are not meant to change
//==========================================================================
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_RESET_PC 32'h00400000   // first fetch address after reset
`define CPU_XLEN     32             // data, address and instruction width
`define CPU_REG_AW   5              // register index width

`endif

// File: cpu_pkg.sv
//==========================================================================
// types shared by all pipeline stages
// a control word of all zeros is a bubble and has no side effect
//==========================================================================
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_idx_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // encodings of the alu_op field in ctrl_t
    localparam logic [1:0] ALU_CLS_ADD   = 2'd0;
    localparam logic [1:0] ALU_CLS_SUB   = 2'd1;
    localparam logic [1:0] ALU_CLS_RTYPE = 2'd2;   // operation taken from funct

    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       mem_to_reg;
        logic       alu_src_imm;
        logic       reg_dst_rd;
        logic       branch;
        logic       branch_ne;
        logic [1:0] alu_op;
    } ctrl_t;

endpackage

// File: fetch_unit.sv
//==========================================================================
// program counter and fetch-to-decode register
// imem_data must be valid in the same cycle as imem_addr
// a squashed slot holds the all-zero word, which decodes as a no-operation
//==========================================================================
`timescale 1ns/1ns
`include "cpu_defs.svh"

module fetch_unit (
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    input  logic           stall_decode,
    input  logic           mem_busy,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t imem_addr,
    output cpu_pkg::word_t d_instr,
    output cpu_pkg::word_t d_pc
);

    cpu_pkg::word_t pc;
    logic           advance;

    assign advance   = !mem_busy && !stall_decode;   // both hold the front end
    assign imem_addr = pc;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc      <= `CPU_RESET_PC;
            d_instr <= '0;
        end
        else if (advance)
        begin
            pc      <= branch_taken ? branch_target : pc + 32'd4;
            d_instr <= branch_taken ? '0 : imem_data;   // no delay slot
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (advance)
            d_pc <= pc;
    end

endmodule

// File: register_file.sv
//==========================================================================
// 32 x 32 register file, two read ports and one write port
// register zero reads as zero and writes to it are dropped
//==========================================================================
`timescale 1ns/1ns

module register_file (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  cpu_pkg::reg_idx_t rs_idx,
    input  cpu_pkg::reg_idx_t rt_idx,
    output cpu_pkg::word_t    rs_data,
    output cpu_pkg::word_t    rt_data,
    input  logic              wb_reg_write,
    input  cpu_pkg::reg_idx_t wb_dest,
    input  cpu_pkg::word_t    wb_data
);

    cpu_pkg::word_t regs [32];

    // write-back value of this cycle wins over the stored word
    function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (wb_reg_write && (wb_dest == idx))
            return wb_data;
        else
            return regs[idx];
    endfunction

    always_comb
    begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_reg_write && (wb_dest != '0))
            regs[wb_dest] <= wb_data;
    end

endmodule

// File: hazard_unit.sv
//==========================================================================
// stall and forward control for the decode stage
// only ALU results of the memory stage are forwarded, loads there stall
//==========================================================================
`timescale 1ns/1ns

module hazard_unit (
    input  cpu_pkg::word_t    d_instr,
    input  cpu_pkg::ctrl_t    ex_ctrl,
    input  cpu_pkg::ctrl_t    mem_ctrl,
    input  cpu_pkg::reg_idx_t ex_dest,
    input  cpu_pkg::reg_idx_t mem_dest,
    output logic              stall_decode,
    output logic              fwd_rs,
    output logic              fwd_rt
);

    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    logic              uses_rs;
    logic              uses_rt;
    logic              ex_rs;
    logic              ex_rt;
    logic              mem_rs;
    logic              mem_rt;

    assign rs = d_instr[25:21];
    assign rt = d_instr[20:16];

    always_comb
    begin
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        case (cpu_pkg::opcode_e'(d_instr[31:26]))
            cpu_pkg::OP_RTYPE, cpu_pkg::OP_SW, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE:
            begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_LW:
                uses_rs = 1'b1;   // rt is the destination here
            default:
                uses_rs = 1'b0;
        endcase
    end

    // source matches, register zero never counts
    assign ex_rs  = uses_rs && (rs != '0) && ex_ctrl.reg_write && (ex_dest == rs);
    assign ex_rt  = uses_rt && (rt != '0) && ex_ctrl.reg_write && (ex_dest == rt);
    assign mem_rs = uses_rs && (rs != '0) && mem_ctrl.reg_write && (mem_dest == rs);
    assign mem_rt = uses_rt && (rt != '0) && mem_ctrl.reg_write && (mem_dest == rt);

    assign stall_decode = ex_rs || ex_rt || (mem_ctrl.mem_read && (mem_rs || mem_rt));
    assign fwd_rs       = mem_rs && !mem_ctrl.mem_read;
    assign fwd_rt       = mem_rt && !mem_ctrl.mem_read;

endmodule

// File: decode_stage.sv
//==========================================================================
// instruction decode, operand read and branch resolution
// unknown opcodes and R-type functions decode as a no-operation
// branch_taken is only acted on when the decode stage is not stalled
//==========================================================================
`timescale 1ns/1ns

module decode_stage (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  cpu_pkg::word_t    d_instr,
    input  cpu_pkg::word_t    d_pc,
    input  logic              fwd_rs,
    input  logic              fwd_rt,
    input  cpu_pkg::word_t    mem_alu_result,
    input  logic              wb_reg_write,
    input  cpu_pkg::reg_idx_t wb_dest,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::ctrl_t    d_ctrl,
    output cpu_pkg::word_t    d_rs_val,
    output cpu_pkg::word_t    d_rt_val,
    output cpu_pkg::word_t    d_imm,
    output cpu_pkg::reg_idx_t d_dest,
    output logic              branch_taken,
    output cpu_pkg::word_t    branch_target
);

    cpu_pkg::word_t rs_data;
    cpu_pkg::word_t rt_data;
    logic           operands_equal;

    register_file u_regs (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .rs_idx       (d_instr[25:21]),
        .rt_idx       (d_instr[20:16]),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .wb_reg_write (wb_reg_write),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data)
    );

    always_comb
    begin
        d_ctrl = '0;
        case (cpu_pkg::opcode_e'(d_instr[31:26]))
            cpu_pkg::OP_RTYPE:
            begin
                case (cpu_pkg::funct_e'(d_instr[5:0]))
                    cpu_pkg::FN_ADD, cpu_pkg::FN_SUB, cpu_pkg::FN_AND,
                    cpu_pkg::FN_OR, cpu_pkg::FN_SLT:
                    begin
                        d_ctrl.reg_write  = 1'b1;
                        d_ctrl.reg_dst_rd = 1'b1;
                        d_ctrl.alu_op     = cpu_pkg::ALU_CLS_RTYPE;
                    end
                    default:
                        d_ctrl = '0;
                endcase
            end
            cpu_pkg::OP_ADDI:
            begin
                d_ctrl.reg_write   = 1'b1;
                d_ctrl.alu_src_imm = 1'b1;
            end
            cpu_pkg::OP_LW:
            begin
                d_ctrl.reg_write   = 1'b1;
                d_ctrl.mem_read    = 1'b1;
                d_ctrl.mem_to_reg  = 1'b1;
                d_ctrl.alu_src_imm = 1'b1;   // address is rs plus offset
            end
            cpu_pkg::OP_SW:
            begin
                d_ctrl.mem_write   = 1'b1;
                d_ctrl.alu_src_imm = 1'b1;
            end
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE:
            begin
                d_ctrl.branch    = 1'b1;
                d_ctrl.branch_ne = d_instr[26];   // bne differs from beq in bit 26
                d_ctrl.alu_op    = cpu_pkg::ALU_CLS_SUB;
            end
            default:
                d_ctrl = '0;
        endcase
    end

    assign d_imm  = {{16{d_instr[15]}}, d_instr[15:0]};
    assign d_dest = d_ctrl.reg_dst_rd ? d_instr[15:11] : d_instr[20:16];

    assign d_rs_val = fwd_rs ? mem_alu_result : rs_data;
    assign d_rt_val = fwd_rt ? mem_alu_result : rt_data;

    // compare on forwarded operands
    assign operands_equal = (d_rs_val == d_rt_val);
    assign branch_taken   = d_ctrl.branch && (d_ctrl.branch_ne ? !operands_equal : operands_equal);
    assign branch_target  = d_pc + 32'd4 + {d_imm[29:0], 2'b00};

endmodule

// File: execute_stage.sv
//==========================================================================
// decode-to-execute register, ALU control and ALU
// overflow is not detected, add and sub wrap
//==========================================================================
`timescale 1ns/1ns

module execute_stage (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  logic              stall_decode,
    input  logic              mem_busy,
    input  cpu_pkg::ctrl_t    d_ctrl,
    input  cpu_pkg::word_t    d_rs_val,
    input  cpu_pkg::word_t    d_rt_val,
    input  cpu_pkg::word_t    d_imm,
    input  cpu_pkg::reg_idx_t d_dest,
    input  logic [5:0]        d_funct,
    output cpu_pkg::ctrl_t    ex_ctrl,
    output cpu_pkg::reg_idx_t ex_dest,
    output cpu_pkg::word_t    ex_alu_result,
    output cpu_pkg::word_t    ex_store_data
);

    cpu_pkg::word_t   rs_val;
    cpu_pkg::word_t   imm;
    cpu_pkg::word_t   operand_b;
    logic [5:0]       funct;
    cpu_pkg::alu_op_e alu_op;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            ex_ctrl <= '0;
            ex_dest <= '0;
        end
        else if (!mem_busy)
        begin
            ex_ctrl <= stall_decode ? '0 : d_ctrl;   // bubble while decode waits
            ex_dest <= d_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!mem_busy)
        begin
            rs_val        <= d_rs_val;
            ex_store_data <= d_rt_val;   // rt doubles as store data
            imm           <= d_imm;
            funct         <= d_funct;
        end
    end

    always_comb
    begin
        case (ex_ctrl.alu_op)
            cpu_pkg::ALU_CLS_SUB:
                alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::ALU_CLS_RTYPE:
            begin
                case (cpu_pkg::funct_e'(funct))
                    cpu_pkg::FN_SUB: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT: alu_op = cpu_pkg::ALU_SLT;
                    default:         alu_op = cpu_pkg::ALU_ADD;
                endcase
            end
            default:
                alu_op = cpu_pkg::ALU_ADD;   // addi, lw, sw
        endcase
    end

    assign operand_b = ex_ctrl.alu_src_imm ? imm : ex_store_data;

    always_comb
    begin
        case (alu_op)
            cpu_pkg::ALU_SUB: ex_alu_result = rs_val - operand_b;
            cpu_pkg::ALU_AND: ex_alu_result = rs_val & operand_b;
            cpu_pkg::ALU_OR:  ex_alu_result = rs_val | operand_b;
            cpu_pkg::ALU_SLT: ex_alu_result = ($signed(rs_val) < $signed(operand_b)) ? 32'd1 : 32'd0;
            default:          ex_alu_result = rs_val + operand_b;
        endcase
    end

endmodule

// File: memory_stage.sv
//==========================================================================
// memory stage with a Wishbone classic master and the write-back register
// full-word accesses only, addresses are assumed word aligned
// mem_busy holds the whole pipeline until wb_ack
//==========================================================================
`timescale 1ns/1ns

module memory_stage (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  cpu_pkg::ctrl_t    ex_ctrl,
    input  cpu_pkg::reg_idx_t ex_dest,
    input  cpu_pkg::word_t    ex_alu_result,
    input  cpu_pkg::word_t    ex_store_data,
    output cpu_pkg::ctrl_t    mem_ctrl,
    output cpu_pkg::reg_idx_t mem_dest,
    output cpu_pkg::word_t    mem_alu_result,
    output logic              mem_busy,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output cpu_pkg::word_t    wb_adr,
    output cpu_pkg::word_t    wb_dat_o,
    input  cpu_pkg::word_t    wb_dat_i,
    input  logic              wb_ack,
    output logic              wb_reg_write,
    output cpu_pkg::reg_idx_t wb_dest,
    output cpu_pkg::word_t    wb_data
);

    logic           access;
    logic           wb_mem_to_reg;
    cpu_pkg::word_t wb_alu_result;
    cpu_pkg::word_t wb_load_data;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            mem_ctrl <= '0;
            mem_dest <= '0;
        end
        else if (!mem_busy)
        begin
            mem_ctrl <= ex_ctrl;
            mem_dest <= ex_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!mem_busy)
        begin
            mem_alu_result <= ex_alu_result;
            wb_dat_o       <= ex_store_data;
        end
    end

    // bus signals come straight from the stage register, so they hold until ack
    assign access   = mem_ctrl.mem_read || mem_ctrl.mem_write;
    assign wb_cyc   = access;
    assign wb_stb   = access;   // stays high into the next access when back to back
    assign wb_we    = mem_ctrl.mem_write;
    assign wb_adr   = mem_alu_result;
    assign mem_busy = access && !wb_ack;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
            wb_dest       <= '0;
        end
        else if (!mem_busy)
        begin
            wb_reg_write  <= mem_ctrl.reg_write;
            wb_mem_to_reg <= mem_ctrl.mem_to_reg;
            wb_dest       <= mem_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!mem_busy)
            wb_alu_result <= mem_alu_result;
        if (wb_ack)
            wb_load_data <= wb_dat_i;   // read data valid in the ack cycle
    end

    assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

// File: mips_pipeline.sv
//==========================================================================
// five-stage MIPS32 subset pipeline, top level
// instruction fetch is a combinational port, data goes over Wishbone classic
// no exceptions, no jump, no byte selects
//==========================================================================
`timescale 1ns/1ns

module mips_pipeline (
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_dat_o,
    input  cpu_pkg::word_t wb_dat_i,
    input  logic           wb_ack
);

    cpu_pkg::word_t    d_instr;
    cpu_pkg::word_t    d_pc;
    logic              stall_decode;
    logic              mem_busy;
    logic              branch_taken;
    cpu_pkg::word_t    branch_target;
    logic              fwd_rs;
    logic              fwd_rt;
    cpu_pkg::ctrl_t    d_ctrl;
    cpu_pkg::word_t    d_rs_val;
    cpu_pkg::word_t    d_rt_val;
    cpu_pkg::word_t    d_imm;
    cpu_pkg::reg_idx_t d_dest;
    cpu_pkg::ctrl_t    ex_ctrl;
    cpu_pkg::reg_idx_t ex_dest;
    cpu_pkg::word_t    ex_alu_result;
    cpu_pkg::word_t    ex_store_data;
    cpu_pkg::ctrl_t    mem_ctrl;
    cpu_pkg::reg_idx_t mem_dest;
    cpu_pkg::word_t    mem_alu_result;
    logic              wb_reg_write;
    cpu_pkg::reg_idx_t wb_dest;
    cpu_pkg::word_t    wb_data;

    fetch_unit u_fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall_decode  (stall_decode),
        .mem_busy      (mem_busy),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_data     (imem_data),
        .imem_addr     (imem_addr),
        .d_instr       (d_instr),
        .d_pc          (d_pc)
    );

    hazard_unit u_hazard (
        .d_instr      (d_instr),
        .ex_ctrl      (ex_ctrl),
        .mem_ctrl     (mem_ctrl),
        .ex_dest      (ex_dest),
        .mem_dest     (mem_dest),
        .stall_decode (stall_decode),
        .fwd_rs       (fwd_rs),
        .fwd_rt       (fwd_rt)
    );

    decode_stage u_decode (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .d_instr        (d_instr),
        .d_pc           (d_pc),
        .fwd_rs         (fwd_rs),
        .fwd_rt         (fwd_rt),
        .mem_alu_result (mem_alu_result),
        .wb_reg_write   (wb_reg_write),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data),
        .d_ctrl         (d_ctrl),
        .d_rs_val       (d_rs_val),
        .d_rt_val       (d_rt_val),
        .d_imm          (d_imm),
        .d_dest         (d_dest),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

    execute_stage u_execute (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall_decode  (stall_decode),
        .mem_busy      (mem_busy),
        .d_ctrl        (d_ctrl),
        .d_rs_val      (d_rs_val),
        .d_rt_val      (d_rt_val),
        .d_imm         (d_imm),
        .d_dest        (d_dest),
        .d_funct       (d_instr[5:0]),
        .ex_ctrl       (ex_ctrl),
        .ex_dest       (ex_dest),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data)
    );

    memory_stage u_memory (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .ex_ctrl        (ex_ctrl),
        .ex_dest        (ex_dest),
        .ex_alu_result  (ex_alu_result),
        .ex_store_data  (ex_store_data),
        .mem_ctrl       (mem_ctrl),
        .mem_dest       (mem_dest),
        .mem_alu_result (mem_alu_result),
        .mem_busy       (mem_busy),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_o       (wb_dat_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack         (wb_ack),
        .wb_reg_write   (wb_reg_write),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data)
    );

endmodule

// File: mips_checker.sv
//==========================================================================
// Wishbone handshake and fetch address assertions for mips_pipeline
// concurrent assertions must be enabled in the simulator
//==========================================================================
`timescale 1ns/1ns

module mips_checker (
    input logic           SYS_clk,
    input logic           SYS_reset,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_we,
    input cpu_pkg::word_t wb_adr,
    input cpu_pkg::word_t wb_dat_o,
    input logic           wb_ack,
    input cpu_pkg::word_t imem_addr
);

    stb_within_cyc: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high while wb_cyc is low");

    // request must hold until the slave acks
    request_stable: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o)))
        else $error("Wishbone request changed before wb_ack");

    fetch_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr is not word aligned");

    no_cycle_in_reset: assert property (@(posedge SYS_clk)
        SYS_reset |-> !wb_cyc)
        else $error("wb_cyc high during reset");

endmodule

bind mips_pipeline mips_checker u_checker (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .imem_addr (imem_addr)
);

// File: tb_mips_pipeline.sv
//==========================================================================
// testbench for the MIPS32 subset pipeline
// program, initial data and expected stores come from mips_testdata.txt
// the Wishbone slave answers 1 to 4 cycles after a request
// the first wrong value stops the run
// the program must end with a store to MARKER_ADDR
//==========================================================================
`timescale 1ns/1ns
`include "cpu_defs.svh"

module tb_mips_pipeline;

    localparam cpu_pkg::word_t MARKER_ADDR = 32'h00007ff0;
    localparam cpu_pkg::word_t IMEM_BYTES  = 32'd256;   // 64 words of program space
    localparam int             RUN_TIMEOUT = 4000;

    logic           SYS_clk;
    logic           SYS_reset = 1'b0;
    cpu_pkg::word_t imem_addr;
    cpu_pkg::word_t imem_data;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    cpu_pkg::word_t wb_adr;
    cpu_pkg::word_t wb_dat_o;
    cpu_pkg::word_t wb_dat_i = '0;
    logic           wb_ack = 1'b0;

    cpu_pkg::word_t imem [64] = '{default: '0};
    cpu_pkg::word_t imem_offset;
    logic [6:0]     prog_words = '0;
    cpu_pkg::word_t dmem [cpu_pkg::word_t];
    cpu_pkg::word_t store_adr_q [$];
    cpu_pkg::word_t store_dat_q [$];
    int             expected_stores;
    int             store_count = 0;
    logic           marker_seen = 1'b0;
    logic [31:0]    rng_state = 32'hb11e1bbe;
    logic           pending = 1'b0;   // slave has picked a delay for this access
    logic [1:0]     wait_left = '0;
    int             cycles;

    mips_pipeline UUT (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack)
    );

    // instruction ROM answers in the same cycle
    assign imem_offset = imem_addr - `CPU_RESET_PC;
    assign imem_data   = (imem_offset < IMEM_BYTES) ? imem[imem_offset[7:2]] : '0;

    initial
    begin
        SYS_clk = 1'b0;
        forever #10 SYS_clk = ~SYS_clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // words never written read back as an address-dependent pattern
    function automatic cpu_pkg::word_t read_word(input cpu_pkg::word_t adr);
        if (dmem.exists(adr))
            return dmem[adr];
        else
            return adr ^ 32'hc3a55a3c;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string name, input cpu_pkg::word_t actual,
                                 input cpu_pkg::word_t expected);
        if (actual !== expected)
        begin
            $display("MISMATCH time %0t %s: got %h, expected %h", $time, name, actual, expected);
            abort_run("a checked value differs from its expected value");
        end
    endtask

    task automatic put_program_word(input cpu_pkg::word_t word);
        if (prog_words == 7'd64)
            abort_run("the program in mips_testdata.txt is longer than 64 words");
        imem[prog_words[5:0]] = word;
        prog_words = prog_words + 7'd1;
    endtask

    task automatic load_testdata();
        int                 fd;
        int                 n;
        logic [7:0]         kind;
        logic [8*128-1:0]   rest;
        cpu_pkg::word_t     w0;
        cpu_pkg::word_t     w1;
        cpu_pkg::word_t     w2;
        cpu_pkg::word_t     w3;
        fd = $fopen("mips_testdata.txt", "r");
        if (fd == 0)
            abort_run("could not open mips_testdata.txt");
        while ($fscanf(fd, " %c", kind) == 1)
        begin
            case (kind)
                "#": void'($fgets(rest, fd));   // comment line
                "P":
                begin
                    n = $fscanf(fd, "%h %h %h %h", w0, w1, w2, w3);
                    if (n != 4)
                        abort_run("a P line does not hold four program words");
                    put_program_word(w0);
                    put_program_word(w1);
                    put_program_word(w2);
                    put_program_word(w3);
                end
                "M":
                begin
                    n = $fscanf(fd, "%h %h", w0, w1);
                    if (n != 2)
                        abort_run("an M line does not hold an address and a word");
                    dmem[w0] = w1;
                end
                "S":
                begin
                    n = $fscanf(fd, "%h %h", w0, w1);
                    if (n != 2)
                        abort_run("an S line does not hold an address and a word");
                    store_adr_q.push_back(w0);
                    store_dat_q.push_back(w1);
                end
                default: abort_run("unknown line kind in mips_testdata.txt");
            endcase
        end
        $fclose(fd);
        expected_stores = store_adr_q.size();
    endtask

    task automatic serve_access();
        cpu_pkg::word_t exp_adr;
        cpu_pkg::word_t exp_dat;
        if (!wb_we)
            wb_dat_i <= read_word(wb_adr);   // valid in the ack cycle
        else if (store_adr_q.size() == 0)
            abort_run($sformatf("store to %h after all expected stores were seen", wb_adr));
        else
        begin
            exp_adr = store_adr_q.pop_front();
            exp_dat = store_dat_q.pop_front();
            compare_value("wb_adr", wb_adr, exp_adr);
            compare_value("wb_dat_o", wb_dat_o, exp_dat);
            dmem[wb_adr] = wb_dat_o;
            store_count  = store_count + 1;
            if (wb_adr == MARKER_ADDR)
                marker_seen <= 1'b1;
        end
    endtask

    // Wishbone slave with random wait states
    always @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_ack  <= 1'b0;
            pending = 1'b0;
        end
        else if (wb_ack)
            wb_ack <= 1'b0;   // ack is one cycle wide
        else if (wb_cyc && wb_stb)
        begin
            if (!pending)
            begin
                rng_state = next_random(rng_state);
                wait_left = rng_state[17:16];
                pending   = 1'b1;
            end
            if (wait_left == 2'd0)
            begin
                serve_access();
                pending = 1'b0;
                wb_ack <= 1'b1;
            end
            else
                wait_left = wait_left - 2'd1;
        end
    end

    initial
    begin
        load_testdata();
        SYS_reset <= 1'b1;
        repeat (10) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        cycles = 0;
        while (!marker_seen && cycles < RUN_TIMEOUT)
        begin
            @(posedge SYS_clk);
            cycles = cycles + 1;
        end
        if (!marker_seen)
            abort_run("timeout: the program never stored to the marker address");
        else if (store_count == expected_stores)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
            compare_value("store_count", store_count, expected_stores);
    end

endmodule

// File: mips_testdata.txt
# P: four program words in fetch order from the reset PC
# M: data address and initial word, S: expected store address and data in bus order
P 20010005 20220007 00221820 00612022
P 00612824 00a23025 0083382a ac060200
P ac070204 ac040208 8c080100 21090001
P ac09020c 8c0a0104 0140582a ac0b0210
P ac0a0214 20000063 00220020 ac000218
P 10220002 ac01021c 14220002 ac020300
P ac030304 200c000c 11820002 ac0c0308
P ac0c030c 14820002 ac050220 8c0d0108
P 11a00001 01a17022 ac0e0224 ac0d7ff0
M 00000100 00001234
M 00000104 fffffff0
M 00000108 0000000a
S 00000200 0000000d
S 00000204 00000001
S 00000208 0000000c
S 0000020c 00001235
S 00000210 00000001
S 00000214 fffffff0
S 00000218 00000000
S 0000021c 00000005
S 00000220 00000001
S 00000224 00000005
# last store goes to the marker address
S 00007ff0 0000000a

// File: all.f
+incdir+.
cpu_pkg.sv
fetch_unit.sv
register_file.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_pipeline.sv
mips_checker.sv
tb_mips_pipeline.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and grep the output for the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_mips_pipeline -o tb_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED" && echo "run passed" \
    || { echo "run failed"; exit 1; }
